// File: filelist.f
source/sd_data_pkg.sv
source/sd_data_fifo.sv
source/sd_transfer_ctrl.sv
source/sd_data_regs.sv
source/sd_dat_phy.sv
source/sd_data_top.sv
verification/sd_data_asserts.sv
verification/sd_data_checker.sv
verification/sd_data_tb.sv

// File: verification/sd_data_tb.sv
`timescale 1ns/10ps

module sd_data_tb import sd_data_pkg::*; ();

  localparam int NBITS           = 8 * BLOCK_BYTES;
  localparam int TEST_CYCLES     = (BLOCK_BYTES * 8 + 20) * 16;
  localparam int NUM_TESTS       = 8;
  localparam int WATCHDOG_CYCLES = NUM_TESTS * TEST_CYCLES * 2;

  logic        CLK = 1'b0;
  logic        RESET_L = 1'b0;
  logic        reg_wr = 1'b0;
  logic        reg_addr = 1'b0;
  logic [15:0] reg_wdata = '0;
  logic        tx_req = 1'b0;
  logic [7:0]  tx_data = '0;
  logic        rx_ack = 1'b0;
  logic        dat_in = 1'b1;
  logic        tx_ack;
  logic        rx_req;
  logic [7:0]  rx_data;
  logic        dat_out;
  logic        dat_oe;
  logic        transfer_complete;
  logic        timeout;
  logic        idle;
  logic [3:0]  blocks_left;

  logic [31:0] rng_state = 32'd46;
  logic [7:0]  stim [16 * BLOCK_BYTES];
  logic        card_bits[$];

  sd_data_top uut (
    .CLK               (CLK),
    .RESET_L           (RESET_L),
    .reg_wr            (reg_wr),
    .reg_addr          (reg_addr),
    .reg_wdata         (reg_wdata),
    .tx_req            (tx_req),
    .tx_data           (tx_data),
    .tx_ack            (tx_ack),
    .rx_req            (rx_req),
    .rx_data           (rx_data),
    .rx_ack            (rx_ack),
    .dat_out           (dat_out),
    .dat_oe            (dat_oe),
    .dat_in            (dat_in),
    .transfer_complete (transfer_complete),
    .timeout           (timeout),
    .idle              (idle),
    .blocks_left       (blocks_left)
  );

  sd_data_checker chk (
    .CLK     (CLK),
    .RESET_L (RESET_L),
    .dat_out (dat_out),
    .dat_oe  (dat_oe),
    .rx_req  (rx_req),
    .rx_ack  (rx_ack),
    .rx_data (rx_data)
  );

  bind sd_transfer_ctrl sd_data_asserts u_asserts (
    .CLK               (CLK),
    .RESET_L           (RESET_L),
    .strobe            (blk.strobe),
    .ready             (blk.ready),
    .blk_ack           (blk.blk_ack),
    .transfer_complete (transfer_complete),
    .timeout           (timeout),
    .idle              (idle)
  );

  always #10 CLK = ~CLK;

  // DMA receive side answers every request.
  always @(posedge CLK) begin
    if (!RESET_L) rx_ack <= 1'b0;
    else if (rx_req && !rx_ack) rx_ack <= 1'b1;
    else if (!rx_req && rx_ack) rx_ack <= 1'b0;
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [31:0] next_rand();
    rng_state = xorshift32(rng_state);
    return rng_state;
  endfunction

  // Bits 15..8 are go, write_read, multiple, timeout_enable and the block count.
  function automatic logic [15:0] cfg_word(input logic go, input logic wr,
                                           input logic tmo_en, input logic [3:0] n);
    return {go, wr, (n != 4'd0), tmo_en, n, 8'h00};
  endfunction

  // A transfer moves block count + 1 blocks.
  function automatic int expected_blocks(input logic [15:0] w);
    return int'(w[11:8]) + 1;
  endfunction

  task automatic write_reg(input logic addr, input logic [15:0] data);
    @(posedge CLK);
    reg_wr    <= 1'b1;
    reg_addr  <= addr;
    reg_wdata <= data;
    @(posedge CLK);
    reg_wr <= 1'b0;
  endtask

  task automatic push_bytes(input int nbytes);
    for (int i = 0; i < nbytes; i++) begin
      tx_req  <= 1'b1;
      tx_data <= stim[i];
      do @(posedge CLK); while (!tx_ack);
      tx_req <= 1'b0;
      do @(posedge CLK); while (tx_ack);
    end
  endtask

  // The card stores each written block, then holds busy low.
  task automatic card_accept(input int nblk);
    logic [31:0] r;
    int d;
    for (int b = 0; b < nblk; b++) begin
      do @(posedge CLK); while (!(dat_oe && !dat_out));
      repeat (NBITS) begin
        @(posedge CLK);
        card_bits.push_back(dat_out);
      end
      @(posedge CLK);
      r = next_rand();
      d = int'(r % 5) + 1;
      dat_in <= 1'b0;
      repeat (d) @(posedge CLK);
      dat_in <= 1'b1;
    end
  endtask

  // The card sends each read block after a gap, with start bit, data and end bit.
  task automatic card_send(input int nblk);
    logic [31:0] r;
    int k;
    k = 0;
    do @(posedge CLK); while (idle);
    for (int b = 0; b < nblk; b++) begin
      r = next_rand();
      repeat (8 + int'(r % 8)) @(posedge CLK);
      dat_in <= 1'b0;
      for (int i = 0; i < NBITS; i++) begin
        @(posedge CLK);
        dat_in <= stim[k + i / 8][7 - i % 8];
      end
      k += BLOCK_BYTES;
      @(posedge CLK);
      dat_in <= 1'b1;
    end
  endtask

  task automatic wait_end(input int exp_steps, output bit tc, output bit to);
    int cyc;
    int steps;
    logic [3:0] bl_prev;
    cyc = 0;
    steps = 0;
    do begin
      @(posedge CLK);
      cyc++;
    end while (idle && cyc < TEST_CYCLES);
    bl_prev = blocks_left;
    chk.check_val("blocks_left at start", exp_steps, blocks_left);
    while (!transfer_complete && !timeout && cyc < TEST_CYCLES) begin
      @(posedge CLK);
      cyc++;
      if (blocks_left != bl_prev) begin
        chk.check_val("blocks_left step", int'(bl_prev) - 1, blocks_left);
        bl_prev = blocks_left;
        steps++;
      end
    end
    if (cyc >= TEST_CYCLES) chk.report_error("transfer did not end in time");
    chk.check_val("blocks_left steps", exp_steps, steps);
    chk.check_val("blocks_left at end", 0, blocks_left);
    chk.check_val("idle at end", 1, idle);
    tc = transfer_complete;
    to = timeout;
  endtask

  task automatic wait_rx_bytes(input int nbytes);
    int cyc;
    cyc = 0;
    while (chk.byte_cnt < nbytes && cyc < TEST_CYCLES) begin
      @(posedge CLK);
      cyc++;
    end
    if (chk.byte_cnt < nbytes) chk.report_error("rx bytes were not all delivered in time");
  endtask

  task automatic run_transfer(input string name, input logic wr, input logic tmo_en,
                              input logic [3:0] n, input bit silent);
    logic [15:0] w;
    logic [31:0] r;
    logic [7:0]  cb;
    int nblk;
    int nbytes;
    bit tc;
    bit to;
    w = cfg_word(1'b1, wr, tmo_en, n);
    nblk = expected_blocks(w);
    nbytes = nblk * BLOCK_BYTES;
    chk.begin_test(name);
    card_bits.delete();
    for (int i = 0; i < nbytes; i++) begin
      r = next_rand();
      stim[i] = r[7:0];
      if (!silent) chk.expect_byte(r[7:0]);
    end
    write_reg(ADDR_CFG, w);
    fork
      begin
        if (wr) push_bytes(nbytes);
        else if (!silent) card_send(nblk);
      end
      begin
        if (wr) card_accept(nblk);
      end
      wait_end(int'(n), tc, to);
    join
    if (silent) begin
      chk.check_val("timeout", 1, to);
      chk.check_val("transfer_complete", 0, tc);
    end else begin
      chk.check_val("transfer_complete", 1, tc);
      chk.check_val("timeout", 0, to);
      if (wr) begin
        // Rebuild the bytes the card stored, MSB first.
        for (int i = 0; i < nbytes; i++) begin
          for (int j = 0; j < 8; j++) begin
            cb = {cb[6:0], card_bits[i * 8 + j]};
          end
          chk.check_val($sformatf("card model byte %0d", i), stim[i], cb);
        end
      end else begin
        wait_rx_bytes(nbytes);
      end
    end
    chk.end_test(silent ? 0 : nbytes);
  endtask

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge CLK);
    $display("Watchdog expired after %0d cycles, the run did not finish", WATCHDOG_CYCLES);
    $display("Simulation FAILED");
    $finish;
  end

  initial begin
    logic [31:0] r;
    repeat (3) @(posedge CLK);
    RESET_L <= 1'b1;
    @(posedge CLK);
    chk.begin_test("reset state");
    chk.check_val("idle", 1, idle);
    chk.check_val("transfer_complete", 0, transfer_complete);
    chk.check_val("timeout", 0, timeout);
    chk.check_val("dat_oe", 0, dat_oe);
    chk.check_val("dat_out", 1, dat_out);
    chk.end_test(0);
    run_transfer("write one block", 1'b1, 1'b0, 4'd0, 1'b0);
    r = next_rand();
    run_transfer("write several blocks", 1'b1, 1'b0, 4'(r % 3 + 1), 1'b0);
    r = next_rand();
    run_transfer("read several blocks", 1'b0, 1'b0, 4'(r % 3 + 1), 1'b0);
    write_reg(ADDR_TIMEOUT, 16'd30);
    run_transfer("read timeout", 1'b0, 1'b1, 4'd0, 1'b1);
    run_transfer("read after timeout", 1'b0, 1'b0, 4'd0, 1'b0);
    // This value would start a write transfer if decoded as a config word.
    chk.begin_test("timeout register write");
    write_reg(ADDR_TIMEOUT, 16'hC300);
    repeat (4) begin
      @(posedge CLK);
      chk.check_val("idle", 1, idle);
    end
    chk.end_test(0);
    run_transfer("read after timeout register write", 1'b0, 1'b1, 4'd1, 1'b0);
    $display("Summary: %0d tests, %0d failed, %0d errors, %0d assertion failures",
             chk.tests_run, chk.tests_failed, chk.total_errs,
             uut.u_ctrl.u_asserts.fail_cnt);
    if (chk.total_errs == 0 && chk.tests_failed == 0 &&
        uut.u_ctrl.u_asserts.fail_cnt == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

// File: verification/sd_data_checker.sv
`timescale 1ns/10ps

module sd_data_checker import sd_data_pkg::*; (
  input logic       CLK,
  input logic       RESET_L,
  input logic       dat_out,
  input logic       dat_oe,
  input logic       rx_req,
  input logic       rx_ack,
  input logic [7:0] rx_data
);

  localparam int NBITS = 8 * BLOCK_BYTES;

  string      cur_name = "none";
  logic [7:0] exp_q[$];
  int         byte_cnt = 0;
  int         test_errs = 0;
  int         total_errs = 0;
  int         tests_run = 0;
  int         tests_failed = 0;
  bit         in_frame = 1'b0;
  int         nbit = 0;
  logic [7:0] shreg = '0;

  task automatic note_error();
    test_errs++;
    total_errs++;
  endtask

  task automatic report_error(input string msg);
    $display("ERROR in %s: %s", cur_name, msg);
    note_error();
  endtask

  task automatic check_val(input string what, input int exp, input int act);
    if (exp != act) begin
      $display("CHECK FAILED %s, %s: expected %0d, actual %0d", cur_name, what, exp, act);
      note_error();
    end
  endtask

  task automatic begin_test(input string name);
    cur_name = name;
    test_errs = 0;
    byte_cnt = 0;
    exp_q.delete();
  endtask

  task automatic expect_byte(input logic [7:0] b);
    exp_q.push_back(b);
  endtask

  task automatic end_test(input int exp_bytes);
    check_val("byte count", exp_bytes, byte_cnt);
    tests_run++;
    if (test_errs == 0) begin
      $display("PASS %s", cur_name);
    end else begin
      tests_failed++;
      $display("FAIL %s with %0d errors", cur_name, test_errs);
    end
  endtask

  task automatic take_byte(input logic [7:0] b, input string where);
    logic [7:0] e;
    byte_cnt++;
    if (exp_q.size() == 0) begin
      report_error($sformatf("unexpected byte %h on %s", b, where));
    end else begin
      e = exp_q.pop_front();
      if (b !== e) begin
        $display("CHECK FAILED %s, byte %0d on %s: expected %h, actual %h",
                 cur_name, byte_cnt - 1, where, e, b);
        note_error();
      end
    end
  endtask

  // Card line framing is start bit 0, data MSB first, end bit 1.
  always @(posedge CLK) begin
    if (!RESET_L) begin
      in_frame = 1'b0;
    end else if (!in_frame) begin
      if (dat_oe && !dat_out) begin
        in_frame = 1'b1;
        nbit = 0;
      end
    end else if (!dat_oe) begin
      report_error("dat_oe dropped inside a block");
      in_frame = 1'b0;
    end else if (nbit < NBITS) begin
      shreg = {shreg[6:0], dat_out};
      nbit++;
      if (nbit % 8 == 0) take_byte(shreg, "card line");
    end else begin
      if (!dat_out) report_error("end bit on the card line was not 1");
      in_frame = 1'b0;
    end
  end

  // A byte is taken on the first cycle of each rx request.
  always @(posedge CLK) begin
    if (RESET_L && rx_req && !rx_ack) take_byte(rx_data, "rx_data");
  end

endmodule

// File: verification/sd_data_asserts.sv
`timescale 1ns/10ps

module sd_data_asserts (
  input logic CLK,
  input logic RESET_L,
  input logic strobe,
  input logic ready,
  input logic blk_ack,
  input logic transfer_complete,
  input logic timeout,
  input logic idle
);

  int fail_cnt = 0;

  // A block is only launched into a PHY that is ready.
  strobe_needs_ready: assert property (@(posedge CLK) disable iff (!RESET_L)
    $rose(strobe) |-> $past(ready))
    else begin
      fail_cnt++;
      $error("strobe rose while the PHY was not ready");
    end

  // The PHY acknowledges only a block that is still strobed.
  ack_needs_strobe: assert property (@(posedge CLK) disable iff (!RESET_L)
    $rose(blk_ack) |-> strobe)
    else begin
      fail_cnt++;
      $error("blk_ack rose without an active strobe");
    end

  status_exclusive: assert property (@(posedge CLK) disable iff (!RESET_L)
    !(transfer_complete && timeout))
    else begin
      fail_cnt++;
      $error("transfer_complete and timeout are high together");
    end

  idle_no_strobe: assert property (@(posedge CLK) disable iff (!RESET_L)
    idle |-> !strobe)
    else begin
      fail_cnt++;
      $error("strobe is high while the controller reports idle");
    end

endmodule

// File: source/sd_data_top.sv
`timescale 1ns/10ps

module sd_data_top import sd_data_pkg::*; #(
  parameter int TX_DEPTH = 8,
  parameter int RX_DEPTH = 8
) (
  input  logic        CLK,
  input  logic        RESET_L,
  input  logic        reg_wr,
  input  logic        reg_addr,
  input  logic [15:0] reg_wdata,
  input  logic        tx_req,
  input  logic [7:0]  tx_data,
  output logic        tx_ack,
  output logic        rx_req,
  output logic [7:0]  rx_data,
  input  logic        rx_ack,
  output logic        dat_out,
  output logic        dat_oe,
  input  logic        dat_in,
  output logic        transfer_complete,
  output logic        timeout,
  output logic        idle,
  output logic [3:0]  blocks_left
);

  xfer_cfg_t   cfg;
  logic [15:0] timeout_value;
  logic        go;
  logic        rx_pend;

  sd_fifo_if #(.DEPTH(TX_DEPTH)) tx_bus ();
  sd_fifo_if #(.DEPTH(RX_DEPTH)) rx_bus ();
  sd_blk_if blk_bus ();

  sd_data_regs u_regs (
    .CLK           (CLK),
    .RESET_L       (RESET_L),
    .reg_wr        (reg_wr),
    .reg_addr      (reg_addr),
    .reg_wdata     (reg_word_u'(reg_wdata)),
    .cfg           (cfg),
    .timeout_value (timeout_value),
    .go            (go)
  );

  sd_data_fifo #(.DEPTH(TX_DEPTH)) u_tx_fifo (.CLK(CLK), .RESET_L(RESET_L), .f(tx_bus));
  sd_data_fifo #(.DEPTH(RX_DEPTH)) u_rx_fifo (.CLK(CLK), .RESET_L(RESET_L), .f(rx_bus));

  sd_transfer_ctrl u_ctrl (
    .CLK               (CLK),
    .RESET_L           (RESET_L),
    .cfg               (cfg),
    .timeout_value     (timeout_value),
    .go                (go),
    .blk               (blk_bus),
    .transfer_complete (transfer_complete),
    .timeout           (timeout),
    .idle              (idle),
    .blocks_left       (blocks_left)
  );

  sd_dat_phy #(.BLOCK_BYTES(BLOCK_BYTES)) u_phy (
    .CLK     (CLK),
    .RESET_L (RESET_L),
    .blk     (blk_bus),
    .txf     (tx_bus),
    .rxf     (rx_bus),
    .dat_out (dat_out),
    .dat_oe  (dat_oe),
    .dat_in  (dat_in)
  );

  // Transmit DMA side, one push per req/ack cycle.
  assign tx_bus.wr_en   = tx_req && !tx_ack && !tx_bus.full;
  assign tx_bus.wr_data = tx_data;

  always_ff @(posedge CLK) begin
    if (!RESET_L) begin
      tx_ack <= 1'b0;
    end else if (tx_bus.wr_en) begin
      tx_ack <= 1'b1;
    end else if (!tx_req) begin
      tx_ack <= 1'b0;
    end
  end

  // Receive DMA side, pop only after the previous ack has dropped.
  assign rx_bus.rd_en = !rx_req && !rx_ack && !rx_pend && !rx_bus.empty;

  always_ff @(posedge CLK) begin
    if (!RESET_L) begin
      rx_req  <= 1'b0;
      rx_pend <= 1'b0;
    end else begin
      rx_pend <= rx_bus.rd_en;
      if (rx_pend) begin
        rx_req <= 1'b1;
      end else if (rx_ack) begin
        rx_req <= 1'b0;
      end
    end
  end

  always_ff @(posedge CLK) begin
    if (rx_pend) rx_data <= rx_bus.rd_data;
  end

endmodule

// File: source/sd_dat_phy.sv
`timescale 1ns/10ps

module sd_dat_phy #(
  parameter int BLOCK_BYTES = 4
) (
  input  logic        CLK,
  input  logic        RESET_L,
  sd_blk_if.phy       blk,
  sd_fifo_if.consumer txf,
  sd_fifo_if.producer rxf,
  output logic        dat_out,
  output logic        dat_oe,
  input  logic        dat_in
);

  localparam int NBITS = 8 * BLOCK_BYTES;
  localparam int CW    = $clog2(NBITS);

  localparam logic [3:0] P_IDLE     = 4'd0;
  localparam logic [3:0] P_TX_WAIT  = 4'd1;
  localparam logic [3:0] P_TX_START = 4'd2;
  localparam logic [3:0] P_TX_SHIFT = 4'd3;
  localparam logic [3:0] P_TX_END   = 4'd4;
  localparam logic [3:0] P_BUSY_LO  = 4'd5;
  localparam logic [3:0] P_BUSY_HI  = 4'd6;
  localparam logic [3:0] P_RX_WAIT  = 4'd7;
  localparam logic [3:0] P_RX_SHIFT = 4'd8;
  localparam logic [3:0] P_RX_END   = 4'd9;
  localparam logic [3:0] P_ACK      = 4'd10;

  logic [3:0]    state;
  logic [CW-1:0] bit_cnt;
  logic [7:0]    shreg;
  logic          last_bit;
  logic          tx_fill_ok;

  assign last_bit   = (bit_cnt == CW'(NBITS - 1));
  assign tx_fill_ok = (txf.count >= BLOCK_BYTES);

  // Pop the first byte with the start bit, later bytes two bits early.
  assign txf.rd_en = !blk.abort &&
                     ((state == P_TX_WAIT && tx_fill_ok) ||
                      (state == P_TX_SHIFT && bit_cnt[2:0] == 3'd6 &&
                       bit_cnt < CW'(NBITS - 8)));

  always_ff @(posedge CLK) begin
    if (!RESET_L) begin
      state       <= P_IDLE;
      bit_cnt     <= '0;
      shreg       <= '0;
      blk.ready   <= 1'b1;
      blk.blk_ack <= 1'b0;
      dat_out     <= 1'b1;
      dat_oe      <= 1'b0;
      rxf.wr_en   <= 1'b0;
      rxf.wr_data <= '0;
    end else begin
      rxf.wr_en <= 1'b0;
      if (blk.abort && state != P_IDLE) begin
        state       <= P_IDLE;
        blk.ready   <= 1'b1;
        blk.blk_ack <= 1'b0;
        dat_out     <= 1'b1;
        dat_oe      <= 1'b0;
      end else begin
        case (state)
          P_IDLE: begin
            if (blk.strobe) begin
              blk.ready <= 1'b0;
              state     <= blk.write_read ? P_TX_WAIT : P_RX_WAIT;
            end
          end
          P_TX_WAIT: begin
            if (tx_fill_ok) begin
              dat_oe  <= 1'b1;
              dat_out <= 1'b0;
              state   <= P_TX_START;
            end
          end
          P_TX_START: begin
            dat_out <= txf.rd_data[7];
            shreg   <= {txf.rd_data[6:0], 1'b0};
            bit_cnt <= '0;
            state   <= P_TX_SHIFT;
          end
          P_TX_SHIFT: begin
            bit_cnt <= bit_cnt + 1'b1;
            if (last_bit) begin
              dat_out <= 1'b1;
              state   <= P_TX_END;
            end else if (bit_cnt[2:0] == 3'd7) begin
              dat_out <= txf.rd_data[7];
              shreg   <= {txf.rd_data[6:0], 1'b0};
            end else begin
              dat_out <= shreg[7];
              shreg   <= {shreg[6:0], 1'b0};
            end
          end
          P_TX_END: begin
            dat_oe <= 1'b0;
            state  <= P_BUSY_LO;
          end
          // Card holds the line low while it programs the block.
          P_BUSY_LO: begin
            if (!dat_in) state <= P_BUSY_HI;
          end
          P_BUSY_HI: begin
            if (dat_in) begin
              blk.blk_ack <= 1'b1;
              state       <= P_ACK;
            end
          end
          P_RX_WAIT: begin
            if (!dat_in) begin
              bit_cnt <= '0;
              state   <= P_RX_SHIFT;
            end
          end
          P_RX_SHIFT: begin
            shreg   <= {shreg[6:0], dat_in};
            bit_cnt <= bit_cnt + 1'b1;
            if (bit_cnt[2:0] == 3'd7) begin
              rxf.wr_en   <= 1'b1;
              rxf.wr_data <= {shreg[6:0], dat_in};
            end
            if (last_bit) state <= P_RX_END;
          end
          // End bit cycle.
          P_RX_END: begin
            blk.blk_ack <= 1'b1;
            state       <= P_ACK;
          end
          P_ACK: begin
            if (!blk.strobe) begin
              blk.blk_ack <= 1'b0;
              blk.ready   <= 1'b1;
              state       <= P_IDLE;
            end
          end
          default: state <= P_IDLE;
        endcase
      end
    end
  end

endmodule

// File: source/sd_data_regs.sv
`timescale 1ns/10ps

module sd_data_regs import sd_data_pkg::*; (
  input  logic        CLK,
  input  logic        RESET_L,
  input  logic        reg_wr,
  input  logic        reg_addr,
  input  reg_word_u   reg_wdata,
  output xfer_cfg_t   cfg,
  output logic [15:0] timeout_value,
  output logic        go
);

  always_ff @(posedge CLK) begin
    if (!RESET_L) begin
      cfg           <= '0;
      timeout_value <= '0;
      go            <= 1'b0;
    end else begin
      go <= 1'b0;
      if (reg_wr) begin
        if (reg_addr == ADDR_CFG) begin
          cfg    <= reg_wdata.cfg;
          // Go only fires once, it is never kept in the register.
          cfg.go <= 1'b0;
          go     <= reg_wdata.cfg.go;
        end else if (reg_addr == ADDR_TIMEOUT) begin
          timeout_value <= reg_wdata.tmo.value;
        end
      end
    end
  end

endmodule

// File: source/sd_transfer_ctrl.sv
`timescale 1ns/10ps

interface sd_blk_if;
  logic strobe;
  logic write_read;
  logic abort;
  logic blk_ack;
  logic ready;

  modport ctrl (output strobe, write_read, abort, input blk_ack, ready);
  modport phy (input strobe, write_read, abort, output blk_ack, ready);
endinterface

module sd_transfer_ctrl import sd_data_pkg::*; (
  input  logic        CLK,
  input  logic        RESET_L,
  input  xfer_cfg_t   cfg,
  input  logic [15:0] timeout_value,
  input  logic        go,
  sd_blk_if.ctrl      blk,
  output logic        transfer_complete,
  output logic        timeout,
  output logic        idle,
  output logic [3:0]  blocks_left
);

  localparam logic [1:0] ST_IDLE   = 2'd0;
  localparam logic [1:0] ST_LAUNCH = 2'd1;
  localparam logic [1:0] ST_BLOCK  = 2'd2;

  logic [1:0]  state;
  logic        tmo_en_q;
  logic [15:0] tmo_cnt;

  always_ff @(posedge CLK) begin
    if (!RESET_L) begin
      state             <= ST_IDLE;
      blk.strobe        <= 1'b0;
      blk.write_read    <= 1'b0;
      blk.abort         <= 1'b0;
      tmo_en_q          <= 1'b0;
      tmo_cnt           <= '0;
      blocks_left       <= '0;
      transfer_complete <= 1'b0;
      timeout           <= 1'b0;
      idle              <= 1'b1;
    end else begin
      blk.abort <= 1'b0;
      case (state)
        ST_IDLE: begin
          if (go) begin
            blk.write_read    <= cfg.write_read;
            tmo_en_q          <= cfg.timeout_enable;
            blocks_left       <= cfg.block_count;
            transfer_complete <= 1'b0;
            timeout           <= 1'b0;
            idle              <= 1'b0;
            state             <= ST_LAUNCH;
          end
        end
        // Wait for the PHY to come back before the next block.
        ST_LAUNCH: begin
          if (blk.ready) begin
            blk.strobe <= 1'b1;
            tmo_cnt    <= '0;
            state      <= ST_BLOCK;
          end
        end
        ST_BLOCK: begin
          if (blk.blk_ack) begin
            blk.strobe <= 1'b0;
            if (blocks_left == 4'd0) begin
              transfer_complete <= 1'b1;
              idle              <= 1'b1;
              state             <= ST_IDLE;
            end else begin
              blocks_left <= blocks_left - 4'd1;
              state       <= ST_LAUNCH;
            end
          end else if (tmo_en_q && tmo_cnt == timeout_value) begin
            // Card took too long, kill the block and end the transfer.
            blk.strobe <= 1'b0;
            blk.abort  <= 1'b1;
            timeout    <= 1'b1;
            idle       <= 1'b1;
            state      <= ST_IDLE;
          end else begin
            tmo_cnt <= tmo_cnt + 16'd1;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

endmodule

// File: source/sd_data_fifo.sv
`timescale 1ns/10ps

interface sd_fifo_if #(parameter int DEPTH = 8);
  logic                       wr_en;
  logic [7:0]                 wr_data;
  logic                       rd_en;
  logic [7:0]                 rd_data;
  logic                       full;
  logic                       empty;
  logic [$clog2(DEPTH+1)-1:0] count;

  modport producer (output wr_en, wr_data, input full);
  modport consumer (output rd_en, input rd_data, empty, count);
  modport fifo_side (input wr_en, wr_data, rd_en, output full, empty, count, rd_data);
  modport monitor (input wr_en, wr_data, rd_en, rd_data, full, empty, count);
endinterface

module sd_data_fifo #(
  parameter int DEPTH = 8
) (
  input logic          CLK,
  input logic          RESET_L,
  sd_fifo_if.fifo_side f
);

  localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CW = $clog2(DEPTH + 1);

  logic [7:0]    mem [DEPTH];
  logic [AW-1:0] wr_ptr;
  logic [AW-1:0] rd_ptr;
  logic [CW-1:0] count_q;
  logic          do_wr;
  logic          do_rd;

  function automatic logic [AW-1:0] next_ptr(input logic [AW-1:0] p);
    return (p == AW'(DEPTH - 1)) ? '0 : p + 1'b1;
  endfunction

  assign do_wr   = f.wr_en && !f.full;
  assign do_rd   = f.rd_en && !f.empty;
  assign f.full  = (count_q == CW'(DEPTH));
  assign f.empty = (count_q == '0);
  assign f.count = count_q;

  always_ff @(posedge CLK) begin
    if (!RESET_L) begin
      wr_ptr  <= '0;
      rd_ptr  <= '0;
      count_q <= '0;
    end else begin
      if (do_wr) wr_ptr <= next_ptr(wr_ptr);
      if (do_rd) rd_ptr <= next_ptr(rd_ptr);
      case ({do_wr, do_rd})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  // Read data shows up the cycle after the pop.
  always_ff @(posedge CLK) begin
    if (do_wr) mem[wr_ptr] <= f.wr_data;
    if (do_rd) f.rd_data <= mem[rd_ptr];
  end

endmodule

// File: source/sd_data_pkg.sv
package sd_data_pkg;

  // Bytes carried by one data block on the card line.
  localparam int BLOCK_BYTES = 4;

  localparam logic ADDR_CFG     = 1'b0;
  localparam logic ADDR_TIMEOUT = 1'b1;

  // Transfer configuration view of a register write.
  typedef struct packed {
    logic       go;
    logic       write_read;
    logic       multiple;
    logic       timeout_enable;
    logic [3:0] block_count;
    logic [7:0] reserved;
  } xfer_cfg_t;

  typedef struct packed {
    logic [15:0] value;
  } tmo_word_t;

  // One write word, read as either register depending on the address.
  typedef union packed {
    xfer_cfg_t cfg;
    tmo_word_t tmo;
  } reg_word_u;

endpackage
